// File: nibble_core_pkg.sv
package nibble_core_pkg;

    localparam int XLEN = 32;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ADD, SUB, LOAD, STORE, LUI, AUIPC, JAL, ILLEGAL
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;  // bits 31..12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, read in every format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e         op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;  // already sign extended
        logic [XLEN-1:0] pc;
    } dec_pkt_t;

    typedef struct packed {
        alu_op_e         op;
        logic [4:0]      rd;
        logic [XLEN-1:0] sum;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] pc;
    } exe_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            wrote_rd;
        logic            stored;
        logic [XLEN-1:0] store_addr;
        logic            illegal;
    } retire_t;

endpackage

// File: instr_decode.sv
`timescale 1ns/100ps

module instr_decode import nibble_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  logic       busy,
    input  instr_u     instr,
    input  logic [31:0] pc,
    output logic       dec_valid,
    output dec_pkt_t   dec_pkt,
    output logic [4:0] rs1_idx,
    output logic [4:0] rs2_idx
);

    instr_u   instr_q;
    logic     pending;  // word captured, decode next edge
    dec_pkt_t pkt_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            pending   <= instr_valid & ~busy;  // strobe during busy is dropped
            dec_valid <= pending;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && !busy)
            instr_q <= instr;
        if (pending)
            dec_pkt <= pkt_d;
    end

    always_comb begin
        pkt_d     = '0;
        pkt_d.op  = ILLEGAL;
        pkt_d.pc  = pc;
        case (instr_q.r_fmt.opcode)
            OPC_OP_IMM: if (instr_q.i_fmt.funct3 == 3'b000) begin
                pkt_d.op  = ADD;  // addi, rs2 stays x0
                pkt_d.rd  = instr_q.i_fmt.rd;
                pkt_d.rs1 = instr_q.i_fmt.rs1;
                pkt_d.imm = {{20{instr_q.i_fmt.imm[11]}}, instr_q.i_fmt.imm};
            end
            OPC_OP: if (instr_q.r_fmt.funct3 == 3'b000) begin
                if (instr_q.r_fmt.funct7 == 7'b0000000)
                    pkt_d.op = ADD;
                else if (instr_q.r_fmt.funct7 == 7'b0100000)
                    pkt_d.op = SUB;
                if (pkt_d.op != ILLEGAL) begin
                    pkt_d.rd  = instr_q.r_fmt.rd;
                    pkt_d.rs1 = instr_q.r_fmt.rs1;
                    pkt_d.rs2 = instr_q.r_fmt.rs2;
                end
            end
            OPC_LOAD: if (instr_q.i_fmt.funct3 == 3'b010) begin
                pkt_d.op  = LOAD;
                pkt_d.rd  = instr_q.i_fmt.rd;
                pkt_d.rs1 = instr_q.i_fmt.rs1;
                pkt_d.imm = {{20{instr_q.i_fmt.imm[11]}}, instr_q.i_fmt.imm};
            end
            OPC_STORE: if (instr_q.s_fmt.funct3 == 3'b010) begin
                pkt_d.op  = STORE;
                pkt_d.rs1 = instr_q.s_fmt.rs1;
                pkt_d.rs2 = instr_q.s_fmt.rs2;  // store data
                pkt_d.imm = {{20{instr_q.s_fmt.imm_hi[6]}}, instr_q.s_fmt.imm_hi,
                             instr_q.s_fmt.imm_lo};
            end
            OPC_LUI, OPC_AUIPC: begin
                pkt_d.op  = (instr_q.u_fmt.opcode == OPC_LUI) ? LUI : AUIPC;
                pkt_d.rd  = instr_q.u_fmt.rd;
                pkt_d.imm = {instr_q.u_fmt.imm, 12'b0};
            end
            OPC_JAL: begin
                pkt_d.op  = JAL;
                pkt_d.rd  = instr_q.j_fmt.rd;
                pkt_d.imm = {{11{instr_q.j_fmt.imm20}}, instr_q.j_fmt.imm20,
                             instr_q.j_fmt.imm19_12, instr_q.j_fmt.imm11,
                             instr_q.j_fmt.imm10_1, 1'b0};
            end
            default: ;  // anything else retires as illegal
        endcase
    end

    // register file is read while dec_valid is high
    assign rs1_idx = dec_pkt.rs1;
    assign rs2_idx = dec_pkt.rs2;

endmodule

// File: nibble_adder.sv
`timescale 1ns/100ps

module nibble_adder (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [3:0] a_nib,
    input  logic [3:0] b_nib,
    input  logic       sub,
    output logic [3:0] sum_nib
);

    logic       carry_q;
    logic       carry_in;
    logic [4:0] total;

    // first step takes sub as carry in, b is already inverted then
    assign carry_in = start ? sub : carry_q;
    assign total    = {1'b0, a_nib} + {1'b0, b_nib} + {4'b0, carry_in};
    assign sum_nib  = total[3:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            carry_q <= 1'b0;
        else
            carry_q <= total[4];  // into the next nibble
    end

endmodule

// File: execute_unit.sv
`timescale 1ns/100ps

module execute_unit import nibble_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic        dec_valid,
    input  dec_pkt_t    dec_pkt,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic        exe_valid,
    output exe_pkt_t    exe_pkt,
    output logic        busy
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] a_sr;  // operands still to go, low nibble next
    logic [XLEN-1:0] b_sr;
    logic [2:0]      nib_idx;
    logic            running;
    logic [3:0]      a_nib;
    logic [3:0]      b_nib;
    logic [3:0]      sum_nib;

    always_comb begin
        op_a = rs1_val;
        op_b = dec_pkt.imm;
        case (dec_pkt.op)
            ADD:        op_b = rs2_val | dec_pkt.imm;  // add has imm 0, addi has rs2 = x0
            SUB:        op_b = ~rs2_val;
            LUI:        op_a = '0;
            AUIPC, JAL: op_a = dec_pkt.pc;
            default: ;
        endcase
    end

    // nibble 0 goes straight from the operand mux
    assign a_nib = dec_valid ? op_a[3:0] : a_sr[3:0];
    assign b_nib = dec_valid ? op_b[3:0] : b_sr[3:0];

    nibble_adder u_adder (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (dec_valid),
        .a_nib   (a_nib),
        .b_nib   (b_nib),
        .sub     (dec_pkt.op == SUB),
        .sum_nib (sum_nib)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            nib_idx   <= 3'd0;
            exe_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            exe_valid <= running && nib_idx == 3'd7;
            if (dec_valid) begin
                running <= 1'b1;
                nib_idx <= 3'd1;
            end else if (running) begin
                nib_idx <= nib_idx + 3'd1;
                if (nib_idx == 3'd7)
                    running <= 1'b0;
            end
            if (exe_valid)
                busy <= 1'b0;  // low in the retire cycle
            else if (instr_valid && !busy)
                busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            a_sr               <= op_a >> 4;
            b_sr               <= op_b >> 4;
            exe_pkt.op         <= dec_pkt.op;
            exe_pkt.rd         <= dec_pkt.rd;
            exe_pkt.pc         <= dec_pkt.pc;
            exe_pkt.store_data <= rs2_val;
        end else if (running) begin
            a_sr <= a_sr >> 4;
            b_sr <= b_sr >> 4;
        end
        if (dec_valid || running)
            exe_pkt.sum <= {sum_nib, exe_pkt.sum[XLEN-1:4]};
    end

endmodule

// File: register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val
);

    logic [31:0] regs [1:31];  // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_val = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// File: result_stage.sv
`timescale 1ns/100ps

module result_stage import nibble_core_pkg::*; #(
    parameter logic [31:0] START_ADDR = 32'h00ff0004,
    parameter int          DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exe_valid,
    input  exe_pkt_t    exe_pkt,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic [31:0] pc,
    output logic        retire_valid,
    output retire_t     retire
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0]   word_idx;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] load_data;
    logic            rd_write;

    // low two address bits dropped, word index wraps at the RAM depth
    assign word_idx  = AW'((exe_pkt.sum >> 2) % DMEM_WORDS);
    assign load_data = dmem[word_idx];
    assign pc_plus4  = exe_pkt.pc + 32'd4;

    always_comb begin
        rd_write = 1'b1;
        wr_data  = exe_pkt.sum;
        case (exe_pkt.op)
            LOAD:    wr_data = load_data;
            JAL:     wr_data = pc_plus4;  // link address
            STORE,
            ILLEGAL: rd_write = 1'b0;
            default: ;
        endcase
    end

    assign wr_en   = exe_valid && rd_write && exe_pkt.rd != 5'd0;
    assign wr_addr = exe_pkt.rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= START_ADDR;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= exe_valid;
            if (exe_valid)
                pc <= (exe_pkt.op == JAL) ? exe_pkt.sum : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && exe_pkt.op == STORE)
            dmem[word_idx] <= exe_pkt.store_data;
        if (exe_valid) begin
            retire.pc         <= exe_pkt.pc;
            retire.rd         <= exe_pkt.rd;
            retire.wrote_rd   <= wr_en;
            retire.stored     <= exe_pkt.op == STORE;
            retire.store_addr <= exe_pkt.sum;
            retire.illegal    <= exe_pkt.op == ILLEGAL;
            if (exe_pkt.op == STORE)
                retire.value <= exe_pkt.store_data;
            else
                retire.value <= rd_write ? wr_data : '0;
        end
    end

endmodule

// File: nibble_core.sv
`timescale 1ns/100ps

module nibble_core import nibble_core_pkg::*; #(
    parameter logic [31:0] START_ADDR = 32'h00ff0004,
    parameter int          DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        busy,
    output logic        retire_valid,
    output retire_t     retire
);

    logic        dec_valid;
    dec_pkt_t    dec_pkt;
    logic        exe_valid;
    exe_pkt_t    exe_pkt;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic [31:0] pc;

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .busy        (busy),
        .instr       (instr),
        .pc          (pc),
        .dec_valid   (dec_valid),
        .dec_pkt     (dec_pkt),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .dec_valid   (dec_valid),
        .dec_pkt     (dec_pkt),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .exe_valid   (exe_valid),
        .exe_pkt     (exe_pkt),
        .busy        (busy)
    );

    register_file u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    result_stage #(
        .START_ADDR (START_ADDR),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .exe_valid    (exe_valid),
        .exe_pkt      (exe_pkt),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: nibble_core_assertions.sv
`timescale 1ns/100ps

module nibble_core_assertions import nibble_core_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    instr_valid,
    input logic    busy,
    input logic    retire_valid,
    input retire_t retire
);

    // host must hold off while an instruction is in flight
    strobe_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> !busy)
        else $error("instr_valid strobe while busy");

    // retire rises at edge 10, first sampled one edge later
    retire_latency: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid == $past(instr_valid && !busy, 11))
        else $error("retire_valid not 10 cycles after the accepted strobe");

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !retire_valid && !busy)
        else $error("core not idle when reset is released");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !(retire.wrote_rd && retire.rd == 5'd0))
        else $error("retire reports a write to x0");

endmodule

bind nibble_core nibble_core_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .busy         (busy),
    .retire_valid (retire_valid),
    .retire       (retire)
);

// File: tb_nibble_core.sv
`timescale 1ns/100ps

module tb_nibble_core import nibble_core_pkg::*; ();

    localparam logic [31:0] START_ADDR   = 32'h00ff0004;
    localparam int          DMEM_WORDS   = 64;
    localparam int          MEM_AW       = $clog2(DMEM_WORDS);
    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 8;
    // reset, arith, memory, upper, jumps, illegal
    localparam int          NUM_INSTR    = 2 + 27 + 24 + 8 + 8 + 8;
    localparam int          WATCHDOG_NS  = (NUM_INSTR * 12 + RESET_CYCLES + 100) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        busy;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] lfsr_state;
    logic [31:0] ref_regs [32];  // model of the register file
    logic [31:0] ref_mem [DMEM_WORDS];
    logic [31:0] ref_pc;
    retire_t     exp_q [$];
    int          strobe_q [$];   // edge 0 of each outstanding instruction
    int          cycle_cnt = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          test_instr = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          retired = 0;
    string       current_test = "none";

    nibble_core #(
        .START_ADDR (START_ADDR),
        .DMEM_WORDS (DMEM_WORDS)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .busy         (busy),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [31:0] itype_word(input logic [31:0] imm, input logic [31:0] rs1,
            input logic [2:0] f3, input logic [31:0] rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [31:0] rs2,
            input logic [31:0] rs1, input logic [2:0] f3, input logic [31:0] rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] stype_word(input logic [31:0] imm, input logic [31:0] rs2,
            input logic [31:0] rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] utype_word(input logic [31:0] imm20, input logic [31:0] rd,
            input logic [6:0] opc);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [31:0] off, input logic [31:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [MEM_AW-1:0] mem_index(input logic [31:0] addr);
        return MEM_AW'((addr >> 2) % DMEM_WORDS);  // word address, wraps at the depth
    endfunction

    // expected retire for one word, advances the model
    function automatic retire_t reference_retire(input logic [31:0] word);
        retire_t     r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        logic        writes;
        opc     = word[6:0];
        rd      = word[11:7];
        f3      = word[14:12];
        f7      = word[31:25];
        a       = ref_regs[word[19:15]];
        b       = ref_regs[word[24:20]];
        imm_i   = {{20{word[31]}}, word[31:20]};
        imm_s   = {{20{word[31]}}, word[31:25], word[11:7]};
        imm_u   = {word[31:12], 12'h000};
        imm_j   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        r       = '0;
        r.pc    = ref_pc;
        r.rd    = rd;
        next_pc = ref_pc + 32'd4;
        writes  = 1'b1;
        case (opc)
            OPC_OP_IMM: begin
                if (f3 == 3'd0)
                    r.value = a + imm_i;
                else
                    r.illegal = 1'b1;
            end
            OPC_OP: begin
                if (f3 == 3'd0 && f7 == 7'h00)
                    r.value = a + b;
                else if (f3 == 3'd0 && f7 == 7'h20)
                    r.value = a - b;
                else
                    r.illegal = 1'b1;
            end
            OPC_LOAD: begin
                if (f3 == 3'd2)
                    r.value = ref_mem[mem_index(a + imm_i)];
                else
                    r.illegal = 1'b1;
            end
            OPC_STORE: begin
                if (f3 == 3'd2) begin
                    r.stored     = 1'b1;
                    r.store_addr = a + imm_s;
                    r.value      = b;
                    writes       = 1'b0;
                    ref_mem[mem_index(a + imm_s)] = b;
                end else begin
                    r.illegal = 1'b1;
                end
            end
            OPC_LUI:   r.value = imm_u;
            OPC_AUIPC: r.value = ref_pc + imm_u;
            OPC_JAL: begin
                r.value = ref_pc + 32'd4;  // link
                next_pc = ref_pc + imm_j;
            end
            default: r.illegal = 1'b1;
        endcase
        if (r.illegal)
            writes = 1'b0;
        r.wrote_rd = writes && rd != 5'd0;
        if (r.wrote_rd)
            ref_regs[rd] = r.value;
        ref_pc = next_pc;
        return r;
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            count_error();
        end
    endtask

    // strobe one word on a falling edge, then wait for busy to drop
    task automatic run_instr(input logic [31:0] word);
        int waited;
        exp_q.push_back(reference_retire(word));
        strobe_q.push_back(cycle_cnt + 1);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
        waited      = 0;
        while (busy !== 1'b0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (busy !== 1'b0) begin
            $display("core still busy 20 cycles after the strobe in test %s", current_test);
            count_error();
        end
        test_instr++;
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
        test_instr   = 0;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d instructions of test %s never retired", exp_q.size(), current_test);
            count_error();
            exp_q.delete();
            strobe_q.delete();
        end
        $display("test %s: %0d instructions, %0d errors", current_test, test_instr, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
    endtask

    initial begin : compare_retire
        retire_t e;
        int      edge0;
        forever begin
            @(negedge clk);  // outputs settled
            if (rst_n && retire_valid) begin
                if (exp_q.size() == 0) begin
                    $display("retire at pc %h with no instruction outstanding", retire.pc);
                    count_error();
                end else begin
                    e     = exp_q.pop_front();
                    edge0 = strobe_q.pop_front();
                    check_value({current_test, " pc"}, e.pc, retire.pc);
                    if (!e.illegal && !e.stored)
                        check_value({current_test, " rd"}, 32'(e.rd), 32'(retire.rd));
                    if (!e.illegal)
                        check_value({current_test, " value"}, e.value, retire.value);
                    check_value({current_test, " wrote_rd"}, 32'(e.wrote_rd),
                                32'(retire.wrote_rd));
                    check_value({current_test, " stored"}, 32'(e.stored), 32'(retire.stored));
                    check_value({current_test, " illegal"}, 32'(e.illegal),
                                32'(retire.illegal));
                    if (e.stored)
                        check_value({current_test, " store_addr"}, e.store_addr,
                                    retire.store_addr);
                    // busy drops in the retire cycle
                    check_value({current_test, " busy at retire"}, 32'd0, 32'(busy));
                    if (cycle_cnt - edge0 != 10) begin
                        $display("retire in test %s came %0d edges after the strobe, not 10",
                                 current_test, cycle_cnt - edge0);
                        count_error();
                    end
                    retired++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] rd;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'h2c86;
        ref_pc      = START_ADDR;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            ref_mem[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset");
        @(negedge clk);
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset retire_valid", 32'd0, 32'(retire_valid));
        run_instr(itype_word(random_bits(12), 0, 3'd0, 1, OPC_OP_IMM));  // pc is START_ADDR
        run_instr(itype_word(random_bits(12), 1, 3'd0, 2, OPC_OP_IMM));
        finish_test();

        start_test("arith");
        for (int i = 0; i < 8; i++)
            run_instr(itype_word(random_bits(12), random_bits(4), 3'd0, random_bits(4) + 1,
                                 OPC_OP_IMM));
        run_instr(itype_word(32'hfff, 0, 3'd0, 5, OPC_OP_IMM));  // x5 = -1
        run_instr(itype_word(1, 0, 3'd0, 6, OPC_OP_IMM));
        run_instr(rtype_word(7'h00, 6, 5, 3'd0, 7));  // carry ripples through all nibbles
        run_instr(rtype_word(7'h20, 5, 6, 3'd0, 8));
        run_instr(rtype_word(7'h20, 6, 0, 3'd0, 9));  // borrow all the way up
        for (int i = 0; i < 12; i++) begin
            r = random_bits(1);
            run_instr(rtype_word(r[0] ? 7'h20 : 7'h00, random_bits(4), random_bits(4), 3'd0,
                                 random_bits(4)));
        end
        run_instr(itype_word(5, 1, 3'd0, 0, OPC_OP_IMM));  // x0 as destination
        run_instr(rtype_word(7'h00, 0, 0, 3'd0, 10));
        finish_test();

        start_test("memory");
        for (int i = 0; i < 4; i++) begin
            off = random_bits(6) << 2;
            run_instr(itype_word(random_bits(9) << 2, 0, 3'd0, 20, OPC_OP_IMM));  // base
            run_instr(utype_word(random_bits(20), 11, OPC_LUI));
            run_instr(itype_word(random_bits(12), 11, 3'd0, 11, OPC_OP_IMM));
            run_instr(stype_word(off, 11, 20));
            run_instr(itype_word(off, 20, 3'd2, 21, OPC_LOAD));
            run_instr(itype_word(off + DMEM_WORDS * 4, 20, 3'd2, 22, OPC_LOAD));  // wraps
        end
        finish_test();

        start_test("upper");
        for (int i = 0; i < 4; i++)
            run_instr(utype_word(random_bits(20), random_bits(4) + 1, OPC_LUI));
        for (int i = 0; i < 4; i++)
            run_instr(utype_word(random_bits(20), random_bits(4) + 1, OPC_AUIPC));
        finish_test();

        start_test("jumps");
        for (int i = 0; i < 4; i++) begin
            r   = random_bits(20);
            off = {{11{r[19]}}, r[19:0], 1'b0};
            run_instr(jtype_word(off, random_bits(4) + 1));
            run_instr(itype_word(0, 0, 3'd0, 0, OPC_OP_IMM));  // nop at the target
        end
        finish_test();

        start_test("illegal");
        for (int i = 0; i < 4; i++) begin
            r  = random_bits(25);
            rd = random_bits(4) + 1;
            case (i)
                0: run_instr({r[24:0], 7'b1100011});                       // branch
                1: run_instr(rtype_word(7'h01, r, r >> 5, 3'd0, rd));       // mul
                2: run_instr(itype_word(r, r >> 5, 3'd1, rd, OPC_OP_IMM));  // slli
                default: run_instr(itype_word(r, r >> 5, 3'd0, rd, OPC_LOAD));  // lb
            endcase
            run_instr(itype_word(0, rd, 3'd0, 0, OPC_OP_IMM));  // rd must be unchanged
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d instructions retired, %0d errors",
                 tests_run, tests_failed, retired, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: nibble_core.f
nibble_core_pkg.sv
instr_decode.sv
nibble_adder.sv
execute_unit.sv
register_file.sv
result_stage.sv
nibble_core.sv
nibble_core_assertions.sv
tb_nibble_core.sv

// File: Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_nibble_core -f nibble_core.f -o sim_nibble_core

run: compile
	./obj_dir/sim_nibble_core > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
